/* src/can_rx_pkg.sv */
package can_rx_pkg;

	// ======================================================================
	// Frame field lengths in bits
	// ======================================================================

	// Base identifier
	localparam int ID_A_BITS = 11;
	// Identifier extension, extended frames only
	localparam int ID_B_BITS = 18;
	localparam int DLC_BITS = 4;
	// Eight bytes at most
	localparam int DATA_BITS = 64;
	localparam int CRC_BITS = 15;
	localparam int EOF_BITS = 7;
	// Third intermission bit may already be the next SOF
	localparam int INTERFRAME_BITS = 2;
	// Five equal bits, then a stuff bit of the opposite value
	localparam int STUFF_RUN = 5;

	// CRC-15 generator, x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	localparam logic [CRC_BITS-1:0] CRC_POLY = 15'h4599;

	// ======================================================================
	// Frame FSM states
	// ======================================================================

	// 17 states, so five bits are needed
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_ID_A,
		ST_RTR_SRR,
		ST_IDE,
		ST_ID_B,
		ST_RTR,
		ST_RES1,
		ST_RES0,
		ST_DLC,
		ST_DATA,
		ST_CRC,
		ST_CRC_DELIM,
		ST_ACK_SLOT,
		ST_ACK_DELIM,
		ST_EOF,
		ST_INTERFRAME,
		ST_BUS_WAIT
	} frame_state_t;

	// Error codes, held until the next SOF
	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_STUFF,
		ERR_CRC,
		ERR_FORM,
		ERR_ACK
	} can_error_t;

endpackage

/* src/can_bit_destuffer.sv */
`timescale 1ns/1ns

module can_bit_destuffer (
	input logic clock,
	input logic reset,
	input logic rx_bit,
	input logic sample_point,
	input logic stuff_enable,
	output logic stuff_bit,
	output logic stuff_error
);
	import can_rx_pkg::*;

	// Alternating start value so no false run is seen after reset
	localparam logic [STUFF_RUN-1:0] HIST_INIT = STUFF_RUN'({STUFF_RUN{2'b01}});

	// Last sampled bits, newest in bit 0
	logic [STUFF_RUN-1:0] history;
	logic run_low;
	logic run_high;

	// History sees every bit, stuff bits included
	// A stuff bit starts the next run
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= HIST_INIT;
		else if (sample_point)
			history <= {history[STUFF_RUN-2:0], rx_bit};
	end

	// Full run of equal bits behind the current one
	assign run_low = (history == '0);
	assign run_high = &history;

	// Opposite value after a run is the stuff bit
	assign stuff_bit = sample_point & stuff_enable &
		((run_low & rx_bit) | (run_high & ~rx_bit));

	// Same value again means six equal bits
	assign stuff_error = sample_point & stuff_enable &
		((run_low & ~rx_bit) | (run_high & rx_bit));

endmodule

/* src/can_crc15.sv */
`timescale 1ns/1ns

module can_crc15 (
	input logic clock,
	input logic reset,
	input logic rx_bit,
	input logic crc_clear,
	input logic crc_shift,
	output logic [can_rx_pkg::CRC_BITS-1:0] crc_value
);
	import can_rx_pkg::*;

	logic feedback;
	logic [CRC_BITS-1:0] crc_next;

	// Incoming bit against the top register bit
	assign feedback = rx_bit ^ crc_value[CRC_BITS-1];

	// Shift left, fold in the polynomial when feedback is set
	assign crc_next = {crc_value[CRC_BITS-2:0], 1'b0} ^ (feedback ? CRC_POLY : '0);

	// Clear wins over shift, the SOF bit adds nothing to a zero register
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_clear)
			crc_value <= '0;
		else if (crc_shift)
			crc_value <= crc_next;
	end

endmodule

/* src/can_frame_fsm.sv */
`timescale 1ns/1ns

module can_frame_fsm #(
	parameter int IDLE_WAIT_BITS = 11
) (
	input logic clock,
	input logic reset,
	input logic rx_bit,
	input logic sample_point,
	input logic stuff_bit,
	input logic stuff_error,
	input logic [can_rx_pkg::CRC_BITS-1:0] crc_value,
	output logic stuff_enable,
	output logic crc_clear,
	output logic crc_shift,
	output logic frame_done,
	output logic [can_rx_pkg::ID_A_BITS-1:0] id_a,
	output logic [can_rx_pkg::ID_B_BITS-1:0] id_b,
	output logic ide,
	output logic rtr,
	output logic [can_rx_pkg::DLC_BITS-1:0] dlc,
	output logic [can_rx_pkg::DATA_BITS-1:0] data,
	output logic error_out,
	output can_rx_pkg::can_error_t error_code
);
	import can_rx_pkg::*;

	// Counter holds the longest field or the bus wait, minus one
	localparam int CNT_W = $clog2(IDLE_WAIT_BITS > DATA_BITS ? IDLE_WAIT_BITS : DATA_BITS);

	frame_state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic cnt_zero;
	logic bit_ok;
	logic sof;
	// Bit after the base id, RTR or SRR
	logic srr_rtr;
	logic [CRC_BITS-1:0] crc_rx;
	logic [DLC_BITS-1:0] dlc_next;
	logic [DLC_BITS-1:0] dlc_bytes;
	logic [CNT_W-1:0] data_last;
	logic fixed_recessive;
	logic err_crc;
	logic err_form;
	logic err_ack;
	logic err_any;
	can_error_t err_code;

	// ======================================================================
	// Bit qualification and helper decode
	// ======================================================================

	// Stuff bits are dropped before any field logic
	assign bit_ok = sample_point & ~stuff_bit;
	assign cnt_zero = (bit_cnt == '0);
	assign sof = sample_point & ~rx_bit & (state == ST_IDLE);

	// CRC_DELIM included for a stuff bit after the last CRC bit
	assign stuff_enable = state inside {ST_ID_A, ST_RTR_SRR, ST_IDE, ST_ID_B, ST_RTR,
		ST_RES1, ST_RES0, ST_DLC, ST_DATA, ST_CRC, ST_CRC_DELIM};

	// CRC covers SOF through the last data bit
	assign crc_clear = sof;
	assign crc_shift = bit_ok & (sof | (state inside {ST_ID_A, ST_RTR_SRR, ST_IDE,
		ST_ID_B, ST_RTR, ST_RES1, ST_RES0, ST_DLC, ST_DATA}));

	// Complete DLC on its last bit, capped at eight bytes
	assign dlc_next = {dlc[DLC_BITS-2:0], rx_bit};
	assign dlc_bytes = (dlc_next > DLC_BITS'(8)) ? DLC_BITS'(8) : dlc_next;
	assign data_last = CNT_W'({dlc_bytes, 3'b000} - 1);

	// ======================================================================
	// Error checks
	// ======================================================================

	// Delimiters, EOF and intermission must be recessive
	assign fixed_recessive = state inside {ST_CRC_DELIM, ST_ACK_DELIM, ST_EOF, ST_INTERFRAME};

	assign err_crc = bit_ok & (state == ST_CRC_DELIM) & (crc_value != crc_rx);
	// SRR is judged once IDE shows an extended frame
	assign err_form = bit_ok & (((state == ST_IDE) & rx_bit & ~srr_rtr) |
		(fixed_recessive & ~rx_bit));
	// Some node must have driven the ACK slot dominant
	assign err_ack = bit_ok & (state == ST_ACK_SLOT) & rx_bit;
	assign err_any = stuff_error | err_crc | err_form | err_ack;

	// Priority stuff, CRC, form, ack
	always_comb
	begin
		if (stuff_error)
			err_code = ERR_STUFF;
		else if (err_crc)
			err_code = ERR_CRC;
		else if (err_form)
			err_code = ERR_FORM;
		else if (err_ack)
			err_code = ERR_ACK;
		else
			err_code = ERR_NONE;
	end

	// ======================================================================
	// State, bit counter and status
	// ======================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			frame_done <= 1'b0;
			error_out <= 1'b0;
			error_code <= ERR_NONE;
		end
		else
		begin
			frame_done <= 1'b0;
			error_out <= 1'b0;
			if (err_any)
			begin
				// Drop the frame and wait for a quiet bus
				state <= ST_BUS_WAIT;
				bit_cnt <= CNT_W'(IDLE_WAIT_BITS - 1);
				error_out <= 1'b1;
				error_code <= err_code;
			end
			else if (bit_ok)
			begin
				case (state)
					ST_IDLE:
						if (~rx_bit)
						begin
							state <= ST_ID_A;
							bit_cnt <= CNT_W'(ID_A_BITS - 1);
							error_code <= ERR_NONE;
						end
					ST_ID_A:
						if (cnt_zero)
							state <= ST_RTR_SRR;
						else
							bit_cnt <= bit_cnt - 1'b1;
					ST_RTR_SRR:
						state <= ST_IDE;
					ST_IDE:
						if (rx_bit)
						begin
							state <= ST_ID_B;
							bit_cnt <= CNT_W'(ID_B_BITS - 1);
						end
						else
							// Standard frame has only r0 before DLC
							state <= ST_RES0;
					ST_ID_B:
						if (cnt_zero)
							state <= ST_RTR;
						else
							bit_cnt <= bit_cnt - 1'b1;
					ST_RTR:
						state <= ST_RES1;
					ST_RES1:
						state <= ST_RES0;
					ST_RES0:
					begin
						state <= ST_DLC;
						bit_cnt <= CNT_W'(DLC_BITS - 1);
					end
					ST_DLC:
						if (cnt_zero)
						begin
							// Remote frame or empty data field skips DATA
							if (rtr || dlc_next == '0)
							begin
								state <= ST_CRC;
								bit_cnt <= CNT_W'(CRC_BITS - 1);
							end
							else
							begin
								state <= ST_DATA;
								bit_cnt <= data_last;
							end
						end
						else
							bit_cnt <= bit_cnt - 1'b1;
					ST_DATA:
						if (cnt_zero)
						begin
							state <= ST_CRC;
							bit_cnt <= CNT_W'(CRC_BITS - 1);
						end
						else
							bit_cnt <= bit_cnt - 1'b1;
					ST_CRC:
						if (cnt_zero)
							state <= ST_CRC_DELIM;
						else
							bit_cnt <= bit_cnt - 1'b1;
					ST_CRC_DELIM:
						state <= ST_ACK_SLOT;
					ST_ACK_SLOT:
						state <= ST_ACK_DELIM;
					ST_ACK_DELIM:
					begin
						state <= ST_EOF;
						bit_cnt <= CNT_W'(EOF_BITS - 1);
					end
					ST_EOF:
						if (cnt_zero)
						begin
							// Frame is good once the last EOF bit passes
							frame_done <= 1'b1;
							state <= ST_INTERFRAME;
							bit_cnt <= CNT_W'(INTERFRAME_BITS - 1);
						end
						else
							bit_cnt <= bit_cnt - 1'b1;
					ST_INTERFRAME:
						if (cnt_zero)
							state <= ST_IDLE;
						else
							bit_cnt <= bit_cnt - 1'b1;
					ST_BUS_WAIT:
						// Needs an unbroken run of recessive bits
						if (~rx_bit)
							bit_cnt <= CNT_W'(IDLE_WAIT_BITS - 1);
						else if (cnt_zero)
							state <= ST_IDLE;
						else
							bit_cnt <= bit_cnt - 1'b1;
					default:
						state <= ST_IDLE;
				endcase
			end
		end
	end

	// ======================================================================
	// Field capture
	// ======================================================================

	always_ff @(posedge clock)
	begin
		// Unused extension and data bits read as zero
		if (sof)
		begin
			id_b <= '0;
			data <= '0;
		end
		else if (bit_ok)
		begin
			case (state)
				ST_ID_A: id_a <= {id_a[ID_A_BITS-2:0], rx_bit};
				ST_RTR_SRR: srr_rtr <= rx_bit;
				ST_IDE:
				begin
					ide <= rx_bit;
					// Standard frame, the earlier bit was RTR
					if (~rx_bit)
						rtr <= srr_rtr;
				end
				ST_ID_B: id_b <= {id_b[ID_B_BITS-2:0], rx_bit};
				ST_RTR: rtr <= rx_bit;
				ST_DLC: dlc <= dlc_next;
				ST_DATA: data <= {data[DATA_BITS-2:0], rx_bit};
				ST_CRC: crc_rx <= {crc_rx[CRC_BITS-2:0], rx_bit};
				default: ;
			endcase
		end
	end

endmodule

/* src/can_frame_outbox.sv */
`timescale 1ns/1ns

module can_frame_outbox (
	input logic clock,
	input logic reset,
	input logic frame_done,
	input logic frame_ack,
	input logic [can_rx_pkg::ID_A_BITS-1:0] in_id_a,
	input logic [can_rx_pkg::ID_B_BITS-1:0] in_id_b,
	input logic in_ide,
	input logic in_rtr,
	input logic [can_rx_pkg::DLC_BITS-1:0] in_dlc,
	input logic [can_rx_pkg::DATA_BITS-1:0] in_data,
	output logic frame_req,
	output logic overrun,
	output logic [can_rx_pkg::ID_A_BITS-1:0] id_a,
	output logic [can_rx_pkg::ID_B_BITS-1:0] id_b,
	output logic ide,
	output logic rtr,
	output logic [can_rx_pkg::DLC_BITS-1:0] dlc,
	output logic [can_rx_pkg::DATA_BITS-1:0] data
);
	// Free, request raised, waiting for ack to drop
	typedef enum logic [1:0] {
		OB_FREE,
		OB_REQ,
		OB_ACK_LOW
	} outbox_state_t;

	outbox_state_t state;
	logic accept;

	// Only a free outbox takes a new frame
	assign accept = frame_done & (state == OB_FREE);

	// Four-phase handshake controller
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= OB_FREE;
			overrun <= 1'b0;
		end
		else
		begin
			// Frame arriving mid-handshake is lost
			overrun <= frame_done & (state != OB_FREE);
			case (state)
				OB_FREE:
					if (frame_done)
						state <= OB_REQ;
				OB_REQ:
					if (frame_ack)
						state <= OB_ACK_LOW;
				OB_ACK_LOW:
					// Next request only after ack is low again
					if (~frame_ack)
						state <= OB_FREE;
				default:
					state <= OB_FREE;
			endcase
		end
	end

	assign frame_req = (state == OB_REQ);

	// Holding copy, stable while the request is up
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			id_a <= in_id_a;
			id_b <= in_id_b;
			ide <= in_ide;
			rtr <= in_rtr;
			dlc <= in_dlc;
			data <= in_data;
		end
	end

endmodule

/* src/can_rx_top.sv */
`timescale 1ns/1ns

module can_rx_top #(
	parameter int IDLE_WAIT_BITS = 11
) (
	input logic clock,
	input logic reset,
	input logic rx_bit,
	input logic sample_point,
	input logic frame_ack,
	output logic frame_req,
	output logic overrun,
	output logic [can_rx_pkg::ID_A_BITS-1:0] id_a,
	output logic [can_rx_pkg::ID_B_BITS-1:0] id_b,
	output logic ide,
	output logic rtr,
	output logic [can_rx_pkg::DLC_BITS-1:0] dlc,
	output logic [can_rx_pkg::DATA_BITS-1:0] data,
	output logic error_out,
	output can_rx_pkg::can_error_t error_code
);
	import can_rx_pkg::*;

	// ======================================================================
	// Internal wiring
	// ======================================================================

	// Destuffer to FSM
	logic stuff_enable;
	logic stuff_bit;
	logic stuff_error;
	// CRC engine control and result
	logic crc_clear;
	logic crc_shift;
	logic [CRC_BITS-1:0] crc_value;
	// Decoded frame from the FSM
	logic frame_done;
	logic [ID_A_BITS-1:0] f_id_a;
	logic [ID_B_BITS-1:0] f_id_b;
	logic f_ide;
	logic f_rtr;
	logic [DLC_BITS-1:0] f_dlc;
	logic [DATA_BITS-1:0] f_data;

	can_bit_destuffer destuffer0 (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_enable(stuff_enable),
		.stuff_bit(stuff_bit),
		.stuff_error(stuff_error)
	);

	can_crc15 crc0 (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.crc_clear(crc_clear),
		.crc_shift(crc_shift),
		.crc_value(crc_value)
	);

	can_frame_fsm #(
		.IDLE_WAIT_BITS(IDLE_WAIT_BITS)
	) fsm0 (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_bit(stuff_bit),
		.stuff_error(stuff_error),
		.crc_value(crc_value),
		.stuff_enable(stuff_enable),
		.crc_clear(crc_clear),
		.crc_shift(crc_shift),
		.frame_done(frame_done),
		.id_a(f_id_a),
		.id_b(f_id_b),
		.ide(f_ide),
		.rtr(f_rtr),
		.dlc(f_dlc),
		.data(f_data),
		.error_out(error_out),
		.error_code(error_code)
	);

	// Consumer side of the frame hand-off
	can_frame_outbox outbox0 (
		.clock(clock),
		.reset(reset),
		.frame_done(frame_done),
		.frame_ack(frame_ack),
		.in_id_a(f_id_a),
		.in_id_b(f_id_b),
		.in_ide(f_ide),
		.in_rtr(f_rtr),
		.in_dlc(f_dlc),
		.in_data(f_data),
		.frame_req(frame_req),
		.overrun(overrun),
		.id_a(id_a),
		.id_b(id_b),
		.ide(ide),
		.rtr(rtr),
		.dlc(dlc),
		.data(data)
	);

endmodule

/* testbench/can_rx_sva.sv */
`timescale 1ns/1ns

module can_rx_sva (
	input logic clock,
	input logic reset,
	input logic frame_req,
	input logic frame_ack,
	input logic frame_done,
	input logic error_out,
	input can_rx_pkg::can_error_t error_code
);
	import can_rx_pkg::*;

	// Failure count read by the testbench
	int fail_count = 0;

	// Request stays up until the consumer acks
	req_held: assert property (@(posedge clock) disable iff (reset)
		frame_req && !frame_ack |=> frame_req)
		else
		begin
			$error("frame_req fell while frame_ack was low");
			fail_count++;
		end

	// No new request before ack is low again
	req_after_ack: assert property (@(posedge clock) disable iff (reset)
		!frame_req && frame_ack |=> !frame_req)
		else
		begin
			$error("frame_req rose while frame_ack was high");
			fail_count++;
		end

	err_single: assert property (@(posedge clock) disable iff (reset)
		error_out |=> !error_out)
		else
		begin
			$error("error_out lasted more than one cycle");
			fail_count++;
		end

	// Errored frames are never handed out
	// A delivered frame saw no error since its SOF
	err_no_frame: assert property (@(posedge clock) disable iff (reset)
		frame_done |-> !error_out && error_code == ERR_NONE)
		else
		begin
			$error("frame delivered with an error since its SOF");
			fail_count++;
		end

endmodule

/* testbench/can_rx_tb.sv */
`timescale 1ns/1ns

module can_rx_tb;
	import can_rx_pkg::*;

	// Bit time of four clocks
	// Watchdog sized for 8 frames of 160 bits
	localparam int CLK_NS = 40;
	localparam int BIT_CLKS = 4;
	localparam int WATCHDOG_NS = 8 * 160 * BIT_CLKS * CLK_NS;

	logic clock = 1'b0;
	logic reset;
	logic rx_bit;
	logic sample_point;
	logic frame_ack;
	logic frame_req;
	logic overrun;
	logic [ID_A_BITS-1:0] id_a;
	logic [ID_B_BITS-1:0] id_b;
	logic ide;
	logic rtr;
	logic [DLC_BITS-1:0] dlc;
	logic [DATA_BITS-1:0] data;
	logic error_out;
	can_error_t error_code;

	integer seed;
	logic hold_ack;
	// Consumer copy of each delivered frame
	int got_count = 0;
	logic [ID_A_BITS-1:0] got_id_a;
	logic [ID_B_BITS-1:0] got_id_b;
	logic got_ide;
	logic got_rtr;
	logic [DLC_BITS-1:0] got_dlc;
	logic [DATA_BITS-1:0] got_data;
	// Error and overrun pulses seen
	int err_count = 0;
	int ovr_count = 0;
	can_error_t last_code;

	can_rx_top #(
		.IDLE_WAIT_BITS(11)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.frame_ack(frame_ack),
		.frame_req(frame_req),
		.overrun(overrun),
		.id_a(id_a),
		.id_b(id_b),
		.ide(ide),
		.rtr(rtr),
		.dlc(dlc),
		.data(data),
		.error_out(error_out),
		.error_code(error_code)
	);

	bind can_rx_top can_rx_sva sva0 (
		.clock(clock),
		.reset(reset),
		.frame_req(frame_req),
		.frame_ack(frame_ack),
		.frame_done(frame_done),
		.error_out(error_out),
		.error_code(error_code)
	);

	initial
		forever #(CLK_NS / 2) clock = ~clock;

	task automatic report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "Stopped at the first failing check");
	endtask

	// One bus bit with the strobe in the first of four clocks
	task automatic send_bit(input logic b);
		@(negedge clock);
		rx_bit = b;
		sample_point = 1'b1;
		@(negedge clock);
		sample_point = 1'b0;
		repeat (BIT_CLKS - 2) @(negedge clock);
	endtask

	task automatic send_idle(input int n);
		repeat (n) send_bit(1'b1);
	endtask

	// ======================================================================
	// Frame builder with CRC and stuffing
	// ======================================================================

	task automatic send_frame(input logic ext, input logic remote, input logic [10:0] ida,
			input logic [17:0] idb, input logic [3:0] len, input logic [63:0] dat,
			input logic [14:0] crc_flip, input logic ack_val, input int eof_dom);
		logic raw[$];
		logic line[$];
		logic [CRC_BITS-1:0] crc;
		logic fb;
		logic last;
		int run;
		int i;
		raw.push_back(1'b0);
		for (i = ID_A_BITS - 1; i >= 0; i--)
			raw.push_back(ida[i]);
		if (ext)
		begin
			// SRR and IDE recessive before the extension
			raw.push_back(1'b1);
			raw.push_back(1'b1);
			for (i = ID_B_BITS - 1; i >= 0; i--)
				raw.push_back(idb[i]);
			raw.push_back(remote);
			raw.push_back(1'b0);
			raw.push_back(1'b0);
		end
		else
		begin
			raw.push_back(remote);
			raw.push_back(1'b0);
			raw.push_back(1'b0);
		end
		for (i = DLC_BITS - 1; i >= 0; i--)
			raw.push_back(len[i]);
		if (!remote)
			for (i = 8 * len - 1; i >= 0; i--)
				raw.push_back(dat[i]);
		// CRC-15 over SOF through data with MSB first
		crc = '0;
		foreach (raw[k])
		begin
			fb = raw[k] ^ crc[CRC_BITS-1];
			crc = {crc[CRC_BITS-2:0], 1'b0} ^ (fb ? CRC_POLY : 15'd0);
		end
		crc = crc ^ crc_flip;
		for (i = CRC_BITS - 1; i >= 0; i--)
			raw.push_back(crc[i]);
		// Stuff bit opens the next run
		run = 0;
		foreach (raw[k])
		begin
			line.push_back(raw[k]);
			if (run > 0 && raw[k] == last)
				run++;
			else
			begin
				run = 1;
				last = raw[k];
			end
			if (run == STUFF_RUN)
			begin
				line.push_back(~last);
				last = ~last;
				run = 1;
			end
		end
		// CRC delimiter, ACK slot, ACK delimiter
		line.push_back(1'b1);
		line.push_back(ack_val);
		line.push_back(1'b1);
		for (i = 0; i < EOF_BITS; i++)
			line.push_back(i == eof_dom ? 1'b0 : 1'b1);
		for (i = 0; i <= INTERFRAME_BITS; i++)
			line.push_back(1'b1);
		foreach (line[k])
			send_bit(line[k]);
	endtask

	task automatic check_frame(input logic ext, input logic remote, input logic [10:0] ida,
			input logic [17:0] idb, input logic [3:0] len, input logic [63:0] dat);
		logic [63:0] exp_data;
		exp_data = remote ? 64'd0 : dat & ((64'd1 << (8 * len)) - 64'd1);
		assert (got_id_a == ida)
			else report_failure($sformatf("id_a is %h, expected %h", got_id_a, ida));
		assert (got_id_b == (ext ? idb : 18'd0))
			else report_failure($sformatf("id_b is %h, expected %h", got_id_b, idb));
		assert (got_ide == ext) else report_failure("ide does not match the frame format");
		assert (got_rtr == remote) else report_failure("rtr does not match the frame type");
		assert (got_dlc == len)
			else report_failure($sformatf("dlc is %0d, expected %0d", got_dlc, len));
		assert (got_data == exp_data)
			else report_failure($sformatf("data is %h, expected %h", got_data, exp_data));
	endtask

	// ======================================================================
	// Consumer, monitors and watchdog
	// ======================================================================

	// Acks 1 to 6 clocks after the request unless held off
	initial
	begin
		int delay;
		forever
		begin
			@(negedge clock);
			if (frame_req && !frame_ack)
			begin
				got_id_a = id_a;
				got_id_b = id_b;
				got_ide = ide;
				got_rtr = rtr;
				got_dlc = dlc;
				got_data = data;
				delay = 1 + ($unsigned($random(seed)) % 6);
				got_count++;
				wait (!hold_ack);
				repeat (delay) @(negedge clock);
				frame_ack = 1'b1;
				while (frame_req)
					@(negedge clock);
				frame_ack = 1'b0;
			end
		end
	end

	always @(negedge clock)
	begin
		if (error_out)
		begin
			err_count++;
			last_code = error_code;
		end
		if (overrun)
			ovr_count++;
		if (dut0.sva0.fail_count != 0)
			report_failure("a bound handshake or error pulse assertion failed");
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t ns, the DUT stopped making progress", $time);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run ended by the watchdog");
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial
	begin
		logic [10:0] ida;
		logic [17:0] idb;
		logic [3:0] len;
		logic [63:0] dat;
		logic [10:0] ida_first;
		logic [63:0] dat_first;
		int base_err;
		int base_got;
		int base_ovr;
		seed = 32'hc2bc;
		hold_ack = 1'b0;
		rx_bit = 1'b1;
		sample_point = 1'b0;
		frame_ack = 1'b0;
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		assert (!frame_req && !error_out && !overrun && error_code == ERR_NONE)
			else report_failure("outputs are not idle after reset");
		send_idle(2);

		// Standard data frame with random id and length
		ida = 11'($random(seed));
		len = 4'(1 + ($unsigned($random(seed)) % 8));
		dat[63:32] = $random(seed);
		dat[31:0] = $random(seed);
		base_err = err_count;
		send_frame(1'b0, 1'b0, ida, 18'd0, len, dat, 15'd0, 1'b0, -1);
		wait (got_count == 1);
		check_frame(1'b0, 1'b0, ida, 18'd0, len, dat);
		assert (err_count == base_err) else report_failure("error pulse on a good frame");

		// Extended frame with the top of the extension dominant so stuffing occurs
		ida = 11'($random(seed));
		idb = 18'($random(seed)) & 18'h01fff;
		len = 4'(1 + ($unsigned($random(seed)) % 8));
		dat[63:32] = $random(seed);
		dat[31:0] = $random(seed);
		send_frame(1'b1, 1'b0, ida, idb, len, dat, 15'd0, 1'b0, -1);
		wait (got_count == 2);
		check_frame(1'b1, 1'b0, ida, idb, len, dat);

		// Remote frame of DLC 4 with no data field
		ida = 11'($random(seed));
		send_frame(1'b0, 1'b1, ida, 18'd0, 4'd4, dat, 15'd0, 1'b0, -1);
		wait (got_count == 3);
		check_frame(1'b0, 1'b1, ida, 18'd0, 4'd4, dat);

		// One CRC bit flipped then a good frame
		base_err = err_count;
		base_got = got_count;
		send_frame(1'b0, 1'b0, ida, 18'd0, 4'd2, dat, 15'h0400, 1'b0, -1);
		wait (err_count == base_err + 1);
		assert (last_code == ERR_CRC) else report_failure("bad CRC not reported as ERR_CRC");
		send_idle(11);
		assert (got_count == base_got) else report_failure("frame with a bad CRC delivered");
		ida = 11'($random(seed));
		send_frame(1'b0, 1'b0, ida, 18'd0, 4'd3, dat, 15'd0, 1'b0, -1);
		wait (got_count == base_got + 1);
		check_frame(1'b0, 1'b0, ida, 18'd0, 4'd3, dat);
		assert (error_code == ERR_NONE) else report_failure("error_code not cleared at SOF");

		// Six dominant bits in the id
		base_got = got_count;
		base_err = err_count;
		repeat (7) send_bit(1'b0);
		wait (err_count == base_err + 1);
		assert (last_code == ERR_STUFF) else report_failure("bit run not reported as ERR_STUFF");
		send_idle(11);
		// Recessive ACK slot
		send_frame(1'b0, 1'b0, ida, 18'd0, 4'd1, dat, 15'd0, 1'b1, -1);
		wait (err_count == base_err + 2);
		assert (last_code == ERR_ACK) else report_failure("missing ACK not reported as ERR_ACK");
		send_idle(11);
		// Dominant bit in EOF
		send_frame(1'b0, 1'b0, ida, 18'd0, 4'd1, dat, 15'd0, 1'b0, 3);
		wait (err_count == base_err + 3);
		assert (last_code == ERR_FORM) else report_failure("bad EOF not reported as ERR_FORM");
		send_idle(11);
		assert (got_count == base_got) else report_failure("errored frame was delivered");

		// Back to back frames with the ack held off
		assert (ovr_count == 0)
			else report_failure("overrun pulsed while the consumer kept up");
		hold_ack = 1'b1;
		base_ovr = ovr_count;
		ida_first = 11'($random(seed));
		dat_first = dat;
		send_frame(1'b0, 1'b0, ida_first, 18'd0, 4'd2, dat_first, 15'd0, 1'b0, -1);
		send_frame(1'b0, 1'b0, ~ida_first, 18'd0, 4'd5, ~dat_first, 15'd0, 1'b0, -1);
		wait (ovr_count == base_ovr + 1);
		assert (frame_req) else report_failure("first frame withdrawn before its ack");
		assert (id_a == ida_first && dlc == 4'd2 && data == (dat_first & 64'hffff))
			else report_failure("outputs changed while the first frame was held");
		check_frame(1'b0, 1'b0, ida_first, 18'd0, 4'd2, dat_first);
		hold_ack = 1'b0;
		wait (!frame_req);
		send_idle(4);
		assert (!frame_req && got_count == base_got + 1)
			else report_failure("second frame was presented after an overrun");

		if (dut0.sva0.fail_count != 0)
		begin
			$display("Bound assertions reported failures during the run");
			$display("SOME TESTS FAILED");
			$fatal(1, "Bound assertion failures");
		end
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

/* vlog.f */
src/can_rx_pkg.sv
src/can_bit_destuffer.sv
src/can_crc15.sv
src/can_frame_fsm.sv
src/can_frame_outbox.sv
src/can_rx_top.sv
testbench/can_rx_sva.sv
testbench/can_rx_tb.sv
